//--- compile.f
verilog/bp_pkg.sv
verilog/fetch_index.sv
verilog/pattern_table.sv
verilog/target_buffer.sv
verilog/pred_select.sv
verilog/branch_predictor.sv
tb/tb_branch_predictor.sv

//--- tb/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor;

    logic            aclk = 1'b0;
    logic            aresetn;
    logic            fetch_valid;
    bp_pkg::addr_t   fetch_pc;
    logic            upd_valid;
    bp_pkg::upd_t    upd;
    logic            pred_valid;
    bp_pkg::pred_t   pred;

    // reference model
    bp_pkg::ghr_t    m_ghr;
    bp_pkg::ctr_t    m_ctr    [256];
    logic            m_valid  [16];
    bp_pkg::tag_t    m_tag    [16];
    bp_pkg::addr_t   m_target [16];

    bp_pkg::pred_t   exp_q [$];    // one entry per fetch in flight
    bp_pkg::pred_t   got_pred;
    logic [31:0]     lfsr;
    int              err_cnt;
    int              chk_cnt;

    branch_predictor dut_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .upd_valid   (upd_valid),
        .upd         (upd),
        .pred_valid  (pred_valid),
        .pred        (pred)
    );

    always #5 aclk = ~aclk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic bp_pkg::addr_t pick_pc(input logic [2:0] sel);
        case (sel)
            3'd0:    return 32'h0000_1040;
            3'd1:    return 32'h0000_2040;   // same entry as 0, other tag
            3'd2:    return 32'h0000_1044;
            3'd3:    return 32'h0000_10c8;
            3'd4:    return 32'h0040_0000;
            3'd5:    return 32'h0040_0014;
            3'd6:    return 32'h0000_1054;
            default: return 32'h0000_3040;
        endcase
    endfunction

    task automatic model_reset();
        m_ghr = '0;
        for (int i = 0; i < 256; i++) begin
            m_ctr[i] = 2'b01;
        end
        for (int i = 0; i < 16; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
        end
    endtask

    function automatic bp_pkg::pred_t model_predict(input bp_pkg::addr_t pc);
        bp_pkg::pred_t p;
        logic [3:0]    bi;
        logic          hit;
        bi           = pc[5:2];
        hit          = m_valid[bi] && (m_tag[bi] == pc[31:6]);
        p.gshare_idx = pc[9:2] ^ m_ghr;
        p.taken      = hit && m_ctr[p.gshare_idx][1];
        p.target     = p.taken ? m_target[bi] : pc + 32'd8;
        return p;
    endfunction

    task automatic model_update(input bp_pkg::upd_t u);
        logic [3:0] bi;
        bi = u.pc[5:2];
        if (u.taken && m_ctr[u.gshare_idx] != 2'b11) begin
            m_ctr[u.gshare_idx] = m_ctr[u.gshare_idx] + 2'd1;
        end else if (!u.taken && m_ctr[u.gshare_idx] != 2'b00) begin
            m_ctr[u.gshare_idx] = m_ctr[u.gshare_idx] - 2'd1;
        end
        if (u.taken) begin
            m_valid[bi]  = 1'b1;
            m_tag[bi]    = u.pc[31:6];
            m_target[bi] = u.target;
        end
        m_ghr = {m_ghr[6:0], u.taken};
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic step();
        @(posedge aclk);
        #1;
    endtask

    task automatic drive_fetch(input bp_pkg::addr_t pc);
        fetch_valid = 1'b1;
        fetch_pc    = pc;
        exp_q.push_back(model_predict(pc));   // state as seen at this edge
    endtask

    task automatic collect_pred();
        int            waited;
        bp_pkg::pred_t e;
        waited = 0;
        while (!pred_valid && waited < 20) begin
            step();
            waited++;
        end
        if (!pred_valid) begin
            $display("ERROR: no pred_valid within 20 cycles at %0t", $time);
            err_cnt++;
            finish_run();
        end else if (exp_q.size() == 0) begin
            $display("ERROR: pred_valid at %0t with no fetch outstanding", $time);
            err_cnt++;
        end else begin
            check_val("pred_valid latency", waited, 0);   // fetch edge was one cycle back
            e = exp_q.pop_front();
            check_val("pred.taken", pred.taken, e.taken);
            check_val("pred.target", pred.target, e.target);
            check_val("pred.gshare_idx", pred.gshare_idx, e.gshare_idx);
            got_pred = pred;
        end
    endtask

    task automatic drive_update(input bp_pkg::addr_t pc, input logic taken,
                                input bp_pkg::addr_t target, input bp_pkg::ghr_t gidx);
        bp_pkg::upd_t u;
        u.pc         = pc;
        u.taken      = taken;
        u.target     = target;
        u.gshare_idx = gidx;
        upd_valid    = 1'b1;
        upd          = u;
        step();
        upd_valid    = 1'b0;
        model_update(u);
    endtask

    task automatic lookup_one(input bp_pkg::addr_t pc);
        drive_fetch(pc);
        step();
        fetch_valid = 1'b0;
        collect_pred();
        step();
        check_val("pred_valid", pred_valid, 1'b0);   // strobe lasts one cycle
    endtask

    task automatic test_reset_state();
        bp_pkg::addr_t pc;
        check_val("pred_valid", pred_valid, 1'b0);
        for (int i = 0; i < 8; i += 5) begin
            pc = pick_pc(i[2:0]);
            lookup_one(pc);
            check_val("pred.taken", got_pred.taken, 1'b0);
            check_val("pred.target", got_pred.target, pc + 32'd8);
            check_val("pred.gshare_idx", got_pred.gshare_idx, pc[9:2]);
        end
    endtask

    task automatic test_train_taken();
        bp_pkg::addr_t pc;
        bp_pkg::ghr_t  g;
        pc = pick_pc(0);
        // counter the lookup will read after two more history shifts
        g = pc[9:2] ^ {m_ghr[5:0], 2'b11};
        drive_update(pc, 1'b1, 32'h0000_8000, g);
        drive_update(pc, 1'b1, 32'h0000_8000, g);
        lookup_one(pc);
        check_val("pred.taken", got_pred.taken, 1'b1);
        check_val("pred.target", got_pred.target, 32'h0000_8000);
    endtask

    task automatic test_train_not_taken();
        bp_pkg::addr_t pc;
        bp_pkg::ghr_t  g;
        pc = pick_pc(0);
        // counter climbs to 11 and then falls past 00 over seven shifts
        g = pc[9:2] ^ {m_ghr[0], 7'b110_0000};
        repeat (2) begin
            drive_update(pc, 1'b1, 32'h0000_8000, g);
        end
        repeat (5) begin
            drive_update(pc, 1'b0, 32'hdead_0000, g);
        end
        lookup_one(pc);
        check_val("pred.taken", got_pred.taken, 1'b0);
        check_val("pred.target", got_pred.target, pc + 32'd8);
        // set a counter through another entry, old target must survive
        g = pc[9:2] ^ {m_ghr[5:0], 2'b11};
        drive_update(pick_pc(2), 1'b1, 32'h0000_9000, g);
        drive_update(pick_pc(2), 1'b1, 32'h0000_9000, g);
        lookup_one(pc);
        check_val("pred.taken", got_pred.taken, 1'b1);
        check_val("pred.target", got_pred.target, 32'h0000_8000);
    endtask

    task automatic test_tag_mismatch();
        bp_pkg::addr_t pc;
        bp_pkg::ghr_t  g;
        pc = pick_pc(1);
        g  = pc[9:2] ^ {m_ghr[5:0], 2'b11};
        drive_update(pick_pc(2), 1'b1, 32'h0000_9000, g);
        drive_update(pick_pc(2), 1'b1, 32'h0000_9000, g);
        lookup_one(pc);
        check_val("pred.taken", got_pred.taken, 1'b0);
        check_val("pred.target", got_pred.target, pc + 32'd8);
    endtask

    task automatic test_back_to_back();
        drive_fetch(pick_pc(0));
        step();
        drive_fetch(pick_pc(1));
        collect_pred();
        step();
        drive_fetch(pick_pc(2));
        collect_pred();
        step();
        fetch_valid = 1'b0;
        collect_pred();
        step();
        check_val("pred_valid", pred_valid, 1'b0);
        check_val("fetches outstanding", exp_q.size(), 0);
    endtask

    task automatic test_random();
        bp_pkg::addr_t pc;
        bp_pkg::addr_t tgt;
        logic [31:0]   r;
        logic          tk;
        for (int n = 0; n < 200; n++) begin
            rand_bits(3, r);
            pc = pick_pc(r[2:0]);
            rand_bits(1, r);
            tk = r[0];
            rand_bits(8, r);
            tgt = 32'h0001_0000 | {22'd0, r[7:0], 2'b00};
            drive_update(pc, tk, tgt, pc[9:2] ^ m_ghr);
            rand_bits(3, r);
            lookup_one(pick_pc(r[2:0]));
        end
    endtask

    initial begin
        aresetn     = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        upd_valid   = 1'b0;
        upd         = '0;
        err_cnt     = 0;
        chk_cnt     = 0;
        lfsr        = 32'h1adc80ce;
        model_reset();
        repeat (3) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        test_reset_state();
        test_train_taken();
        test_train_not_taken();
        test_tag_mismatch();
        test_back_to_back();
        test_random();
        finish_run();
    end

endmodule

//--- verilog/bp_pkg.sv
package bp_pkg;

    // instruction address and history widths
    localparam int addr_w      = 32;
    localparam int ghr_w       = 8;
    localparam int btb_idx_w   = 4;    // 16 target buffer entries
    localparam int pht_idx_lsb = 2;    // word aligned fetch
    localparam int tag_w       = addr_w - btb_idx_w - 2;

    localparam logic [1:0] ctr_reset = 2'b01;  // weakly not-taken

    typedef logic [addr_w-1:0]    addr_t;
    typedef logic [ghr_w-1:0]     ghr_t;
    typedef logic [btb_idx_w-1:0] btb_idx_t;
    typedef logic [tag_w-1:0]     tag_t;
    typedef logic [1:0]           ctr_t;

    // read side, formed at fetch
    typedef struct packed {
        addr_t    pc;
        ghr_t     gshare_idx;
        btb_idx_t btb_idx;
    } lookup_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        addr_t target;
    } btb_entry_t;

    // resolved branch coming back for training
    typedef struct packed {
        addr_t pc;
        logic  taken;
        addr_t target;
        ghr_t  gshare_idx;   // index used when it was predicted
    } upd_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
        ghr_t  gshare_idx;
    } pred_t;

endpackage

//--- verilog/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic            aclk,
    input  logic            aresetn,

    // fetch side
    input  logic            fetch_valid,
    input  bp_pkg::addr_t   fetch_pc,

    // resolved branch
    input  logic            upd_valid,
    input  bp_pkg::upd_t    upd,

    // prediction, one cycle after fetch
    output logic            pred_valid,
    output bp_pkg::pred_t   pred
);

    bp_pkg::lookup_t     lookup;
    bp_pkg::ctr_t        rd_ctr;
    bp_pkg::btb_entry_t  rd_entry;

    fetch_index u_fetch_index (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .fetch_pc   (fetch_pc),
        .upd_valid  (upd_valid),
        .upd        (upd),
        .lookup     (lookup)
    );

    pattern_table u_pattern_table (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .rd_idx     (lookup.gshare_idx),
        .rd_ctr     (rd_ctr),
        .upd_valid  (upd_valid),
        .upd        (upd)
    );

    target_buffer u_target_buffer (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .rd_idx     (lookup.btb_idx),
        .rd_entry   (rd_entry),
        .upd_valid  (upd_valid),
        .upd        (upd)
    );

    pred_select u_pred_select (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .fetch_valid (fetch_valid),
        .lookup      (lookup),
        .rd_ctr      (rd_ctr),
        .rd_entry    (rd_entry),
        .pred_valid  (pred_valid),
        .pred        (pred)
    );

endmodule

//--- verilog/fetch_index.sv
`timescale 1ns/1ps

module fetch_index (
    input  logic              aclk,
    input  logic              aresetn,

    input  bp_pkg::addr_t     fetch_pc,

    input  logic              upd_valid,
    input  bp_pkg::upd_t      upd,

    output bp_pkg::lookup_t   lookup
);

    bp_pkg::ghr_t     ghr;
    bp_pkg::ghr_t     pc_hash_bits;
    bp_pkg::btb_idx_t pc_btb_bits;

    // global history, newest outcome in the lsb
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ghr <= '0;
        end else if (upd_valid) begin
            ghr <= {ghr[bp_pkg::ghr_w-2:0], upd.taken};
        end
    end

    assign pc_hash_bits = fetch_pc[bp_pkg::pht_idx_lsb +: bp_pkg::ghr_w];      // pc[9:2]
    assign pc_btb_bits  = fetch_pc[bp_pkg::pht_idx_lsb +: bp_pkg::btb_idx_w];  // pc[5:2]

    // gshare hash of address and history
    always_comb begin
        lookup.pc         = fetch_pc;
        lookup.gshare_idx = pc_hash_bits ^ ghr;
        lookup.btb_idx    = pc_btb_bits;
    end

endmodule

//--- verilog/pattern_table.sv
`timescale 1ns/1ps

module pattern_table (
    input  logic            aclk,
    input  logic            aresetn,

    // lookup side
    input  bp_pkg::ghr_t    rd_idx,
    output bp_pkg::ctr_t    rd_ctr,

    // training side
    input  logic            upd_valid,
    input  bp_pkg::upd_t    upd
);

    bp_pkg::ctr_t pht [2**bp_pkg::ghr_w];

    bp_pkg::ctr_t cur_ctr;
    bp_pkg::ctr_t nxt_ctr;

    assign rd_ctr  = pht[rd_idx];
    assign cur_ctr = pht[upd.gshare_idx];

    // 2-bit saturating count
    always_comb begin
        nxt_ctr = cur_ctr;
        if (upd.taken) begin
            if (cur_ctr != 2'b11) begin
                nxt_ctr = cur_ctr + 2'b01;
            end
        end else begin
            if (cur_ctr != 2'b00) begin
                nxt_ctr = cur_ctr - 2'b01;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < 2**bp_pkg::ghr_w; i++) begin
                pht[i] <= bp_pkg::ctr_reset;
            end
        end else if (upd_valid) begin
            pht[upd.gshare_idx] <= nxt_ctr;   // same edge as the history shift
        end
    end

endmodule

//--- verilog/pred_select.sv
`timescale 1ns/1ps

module pred_select (
    input  logic                aclk,
    input  logic                aresetn,

    input  logic                fetch_valid,
    input  bp_pkg::lookup_t     lookup,
    input  bp_pkg::ctr_t        rd_ctr,
    input  bp_pkg::btb_entry_t  rd_entry,

    output logic                pred_valid,
    output bp_pkg::pred_t       pred
);

    bp_pkg::tag_t   lookup_tag;
    logic           btb_hit;
    logic           take;
    bp_pkg::addr_t  pc_8;

    assign lookup_tag = lookup.pc[bp_pkg::pht_idx_lsb + bp_pkg::btb_idx_w +: bp_pkg::tag_w];
    assign btb_hit    = rd_entry.valid && (rd_entry.tag == lookup_tag);
    assign take       = btb_hit && rd_ctr[1];   // counter msb gives direction
    assign pc_8       = lookup.pc + bp_pkg::addr_t'(8);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= fetch_valid;
        end
    end

    // payload follows the strobe
    always_ff @(posedge aclk) begin
        if (fetch_valid) begin
            pred.taken      <= take;
            pred.target     <= take ? rd_entry.target : pc_8;
            pred.gshare_idx <= lookup.gshare_idx;
        end
    end

endmodule

//--- verilog/target_buffer.sv
`timescale 1ns/1ps

module target_buffer (
    input  logic                aclk,
    input  logic                aresetn,

    // lookup side
    input  bp_pkg::btb_idx_t    rd_idx,
    output bp_pkg::btb_entry_t  rd_entry,

    // training side
    input  logic                upd_valid,
    input  bp_pkg::upd_t        upd
);

    localparam int depth = 2**bp_pkg::btb_idx_w;

    logic           valid_q  [depth];
    bp_pkg::tag_t   tag_q    [depth];
    bp_pkg::addr_t  target_q [depth];

    bp_pkg::btb_idx_t wr_idx;
    bp_pkg::tag_t     wr_tag;
    logic             wr_en;

    // direct mapped, index pc[5:2], tag pc[31:6]
    assign wr_idx = upd.pc[bp_pkg::pht_idx_lsb +: bp_pkg::btb_idx_w];
    assign wr_tag = upd.pc[bp_pkg::pht_idx_lsb + bp_pkg::btb_idx_w +: bp_pkg::tag_w];

    // only taken branches allocate
    assign wr_en  = upd_valid && upd.taken;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < depth; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= upd.target;
        end
    end

    always_comb begin
        rd_entry.valid  = valid_q[rd_idx];
        rd_entry.tag    = tag_q[rd_idx];
        rd_entry.target = target_q[rd_idx];
    end

endmodule
